// File: all.f
+incdir+verilog
verilog/msx_pkg.sv
verilog/upload_pkg.sv
verilog/image_fetch.sv
verilog/record_decoder.sv
verilog/upload_sequencer.sv
verilog/ram_filler.sv
verilog/slot_map.sv
verilog/memory_upload.sv
testbench/tb_memory_upload.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_memory_upload \
   -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed"
   exit $status
fi
echo "Simulation passed"

// File: testbench/tb_memory_upload.sv
`include "upload_cfg.svh"

module tb_memory_upload;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          REGION = 1 << `UPLOAD_UNIT_SHIFT;  // Bytes per size unit
   localparam logic [23:0] SIG    = "MSX";

   logic                      clk;
   logic                      rst = 1'b1;
   logic                      ioctl_download = 1'b0;
   logic [15:0]               ioctl_index = 16'd0;
   logic [`UPLOAD_RAM_AW-1:0] ioctl_addr = '0;
   logic                      reload = 1'b0;
   logic [`UPLOAD_MEM_AW-1:0] mem_addr;
   logic                      mem_rd;
   logic [7:0]                mem_dout = 8'h00;
   logic                      mem_ready = 1'b0;
   logic [`UPLOAD_RAM_AW-1:0] ram_addr;
   logic [7:0]                ram_din;
   logic                      ram_we;
   logic                      ram_ready = 1'b0;
   logic                      busy;
   logic [5:0]                slot_idx = 6'd0;
   msx_pkg::block_t           slot_entry;
   logic [3:0]                ref_idx = 4'd0;
   msx_pkg::lookup_ram_t      ref_entry;
   msx_pkg::msx_type_t        msx_type;
   logic [3:0]                expander_en;

   logic [7:0] image_mem [32768];  // External store contents
   logic [7:0] ram [65536];
   int         img_len;
   int         work_bytes;
   integer     seed = 32'h5da0;
   logic       ram_we_last = 1'b0;
   longint     cycle = 0;
   longint     watch_start = 0;
   longint     watch_limit = 0;    // Zero when disarmed

   memory_upload dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic expect_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
      if (got !== exp)
         stop_with_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   function automatic logic [7:0] init_pattern(input int a);
      return 8'(a ^ (a >> 8) ^ 32'hA5);
   endfunction

   function automatic logic [7:0] payload_byte(input int i);
      return 8'((i * 5) ^ (i >> 8) ^ 32'h3C);
   endfunction

   // Store and RAM models with random ready
   always @(posedge clk) begin
      mem_ready   <= ($random(seed) & 3) != 0;
      ram_ready   <= ($random(seed) & 3) != 0;
      ram_we_last <= ram_we;
      if (mem_rd && mem_ready) begin
         if (mem_addr[`UPLOAD_MEM_AW-1:15] != 0)
            stop_with_error("Image read past the end of the store model");
         mem_dout <= image_mem[mem_addr[14:0]];
      end
      if (ram_we) begin
         if (!ram_ready)
            stop_with_error("RAM written while ram_ready was low");
         if (ram_we_last)
            stop_with_error("RAM written in two consecutive cycles");
         if (ram_addr[`UPLOAD_RAM_AW-1:16] != 0)
            stop_with_error("RAM write outside the modeled range");
         ram[ram_addr[15:0]] <= ram_din;
      end
      if (rst) begin
         for (int a = 0; a < 65536; a++) ram[a] <= init_pattern(a);
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (watch_limit != 0 && cycle - watch_start > watch_limit)
         stop_with_error("Timeout: the load did not finish within its cycle budget");
   end

   function automatic msx_pkg::block_t make_block(input msx_pkg::mapper_t mapper,
                                                  input logic [3:0] ref_ram,
                                                  input logic [1:0] offset);
      msx_pkg::block_t e;
      e.mapper     = mapper;
      e.device     = msx_pkg::DEVICE_NONE;
      e.ref_ram    = ref_ram;
      e.offset_ram = offset;
      return e;
   endfunction

   // Map content after loading the image built at this level
   function automatic msx_pkg::block_t expected_entry(input int level, input int idx);
      msx_pkg::block_t e;
      e = '0;
      if (level >= 1 && idx == 0) e = make_block(msx_pkg::MAPPER_RAM, 4'd0, 2'd0);
      if (level >= 2 && idx == 17) e = make_block(msx_pkg::MAPPER_KONAMI, 4'd1, 2'd0);
      if (level >= 2 && idx == 18) e = make_block(msx_pkg::MAPPER_KONAMI, 4'd1, 2'd1);
      if (level >= 3 && idx == 16) e = make_block(msx_pkg::MAPPER_UNUSED, 4'd0, 2'd2);
      if (level >= 3 && idx == 19) e = make_block(msx_pkg::MAPPER_KONAMI, 4'd1, 2'd0);
      return e;
   endfunction

   function automatic msx_pkg::lookup_ram_t expected_lookup(input int level, input int idx);
      msx_pkg::lookup_ram_t e;
      e = '0;
      if (level >= 1 && idx == 0) e.size = 16'd1;
      if (level >= 2 && idx == 1) begin
         e.addr = REGION[`UPLOAD_RAM_AW-1:0];
         e.size = 16'd1;
         e.ro   = 1'b1;    // Copied data
      end
      return e;
   endfunction

   task automatic put_record(input logic [8*`UPLOAD_RECORD_BYTES-1:0] rec);
      for (int i = 0; i < `UPLOAD_RECORD_BYTES; i++)
         image_mem[img_len + i] = rec[8*(`UPLOAD_RECORD_BYTES-1-i) +: 8];
      img_len += `UPLOAD_RECORD_BYTES;
   endtask

   // Each level adds records to the image of the level below
   task automatic build_image(input int level);
      img_len = 0;
      for (int i = 0; i < 32768; i++) image_mem[i] = 8'h00;
      put_record({SIG, 8'h00, upload_pkg::ROM_RAM, 16'd1, 8'h00, msx_pkg::MAPPER_RAM,
                  8'h02, 8'h00, 8'h01, 32'h0});
      if (level >= 2) begin
         put_record({SIG, 8'h04, upload_pkg::ROM_ROM, 16'd1, 8'h00, msx_pkg::MAPPER_KONAMI,
                     8'h28, 8'h10, 8'h00, 32'h0});  // Blocks 1 and 2, offsets 0 and 1
         for (int i = 0; i < REGION; i++) image_mem[img_len + i] = payload_byte(i);
         img_len += REGION;
      end
      if (level >= 3) begin
         put_record({SIG, 8'h04, upload_pkg::ROM_NONE, 16'd0, 8'h00, msx_pkg::MAPPER_ASCII8,
                     8'h43, 8'h42, 8'h00, 32'h0});  // Block 0 mode 3, block 3 mirrors 1
      end
      if (level >= 4) put_record({SIG, 8'h30, 2'b00, msx_pkg::MSX2P, 4'hA, 88'h0});
      if (level >= 5) begin
         put_record({"MSY", 8'h00, upload_pkg::ROM_RAM, 16'd1, 8'h00, msx_pkg::MAPPER_RAM,
                     8'h02, 8'h00, 8'h01, 32'h0});
         put_record({SIG, 8'h08, upload_pkg::ROM_RAM, 16'd1, 8'h00, msx_pkg::MAPPER_RAM,
                     8'h02, 8'h00, 8'h02, 32'h0});
      end
      work_bytes = img_len + ((level >= 2) ? 2 * REGION : REGION);
   endtask

   task automatic arm_watchdog(input int bytes);
      watch_start = cycle;
      watch_limit = 64'(bytes) * 20 + 1000;
   endtask

   task automatic wait_busy(input logic level);
      @(negedge clk);
      while (busy !== level) @(negedge clk);
   endtask

   task automatic download_and_load();
      arm_watchdog(work_bytes);
      @(posedge clk);
      ioctl_download <= 1'b1;
      ioctl_index    <= 16'(`UPLOAD_IMAGE_INDEX);
      ioctl_addr     <= img_len[`UPLOAD_RAM_AW-1:0];
      @(posedge clk);
      ioctl_download <= 1'b0;
      wait_busy(1'b1);
      wait_busy(1'b0);
      watch_limit = 0;
   endtask

   task automatic check_slot_map(input int level);
      for (int i = 0; i < `UPLOAD_SLOT_BLOCKS; i++) begin
         @(posedge clk);
         slot_idx <= 6'(i);
         @(negedge clk);
         expect_equal($sformatf("slot_entry[%0d]", i), 64'(slot_entry),
                      64'(expected_entry(level, i)));
      end
   endtask

   task automatic check_lookup(input int level);
      for (int i = 0; i < `UPLOAD_LOOKUP_ENTRIES; i++) begin
         @(posedge clk);
         ref_idx <= 4'(i);
         @(negedge clk);
         expect_equal($sformatf("ref_entry[%0d]", i), 64'(ref_entry),
                      64'(expected_lookup(level, i)));
      end
   endtask

   task automatic check_ram(input int level);
      logic [7:0] exp;
      for (int a = 0; a < 3 * REGION; a++) begin
         exp = init_pattern(a);
         if (a < REGION && level >= 1) exp = 8'hFF;
         if (a >= REGION && a < 2 * REGION && level >= 2) exp = payload_byte(a - REGION);
         expect_equal($sformatf("ram[0x%0h]", a), 64'(ram[a]), 64'(exp));
      end
   endtask

   task automatic test_ram_fill();
      expect_equal("busy", 64'(busy), 64'd0);
      expect_equal("ram_we", 64'(ram_we), 64'd0);
      expect_equal("mem_rd", 64'(mem_rd), 64'd0);
      expect_equal("msx_type", 64'(msx_type), 64'(msx_pkg::MSX1));
      expect_equal("expander_en", 64'(expander_en), 64'd0);
      check_slot_map(0);
      check_lookup(0);
      build_image(1);
      download_and_load();
      check_ram(1);
      check_lookup(1);
      check_slot_map(1);
   endtask

   task automatic test_rom_copy();
      build_image(2);
      download_and_load();
      check_ram(2);
      check_lookup(2);
      check_slot_map(2);
   endtask

   task automatic test_block_modes();
      build_image(3);
      download_and_load();
      check_slot_map(3);
      check_lookup(3);
   endtask

   task automatic test_system_record();
      build_image(4);
      download_and_load();
      expect_equal("msx_type", 64'(msx_type), 64'(msx_pkg::MSX2P));
      expect_equal("expander_en", 64'(expander_en), 64'hA);
   endtask

   // Records after the bad one are never read
   task automatic test_bad_signature();
      build_image(5);
      download_and_load();
      expect_equal("mem_addr", 64'(mem_addr), 64'(img_len - `UPLOAD_RECORD_BYTES));
      check_ram(5);
      check_lookup(5);
      check_slot_map(5);
      expect_equal("busy", 64'(busy), 64'd0);
      expect_equal("msx_type", 64'(msx_type), 64'(msx_pkg::MSX2P));
   endtask

   task automatic test_reload();
      @(posedge clk);
      slot_idx <= 6'd17;
      arm_watchdog(work_bytes);
      @(posedge clk);
      reload <= 1'b1;
      @(posedge clk);
      reload <= 1'b0;
      wait_busy(1'b1);
      repeat (`UPLOAD_SLOT_BLOCKS + 1) @(negedge clk);  // Whole map cleared by now
      expect_equal("slot_entry[17] after clear", 64'(slot_entry), 64'd0);
      wait_busy(1'b0);
      watch_limit = 0;
      check_slot_map(5);
      check_lookup(5);
      check_ram(5);
   endtask

   initial begin
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      test_ram_fill();
      test_rom_copy();
      test_block_modes();
      test_system_record();
      test_bad_signature();
      test_reload();
      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: verilog/image_fetch.sv
`include "upload_cfg.svh"

module image_fetch (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      ioctl_download,
   input  logic [15:0]               ioctl_index,
   input  logic [`UPLOAD_RAM_AW-1:0] ioctl_addr,
   input  logic                      reload,
   output logic                      load,
   input  logic                      dec_req,
   input  logic                      fill_req,
   output logic                      byte_valid,
   output logic [7:0]                byte_data,
   output logic                      at_end,
   output logic [`UPLOAD_MEM_AW-1:0] mem_addr,
   output logic                      mem_rd,
   input  logic [7:0]                mem_dout,
   input  logic                      mem_ready
);
   logic                      dl_last;
   logic [`UPLOAD_RAM_AW-1:0] image_size;

   always_ff @(posedge clk) begin
      dl_last <= ioctl_download;
      load    <= reload;
      if (dl_last & ~ioctl_download & (ioctl_index == 16'(`UPLOAD_IMAGE_INDEX))) begin
         image_size <= ioctl_addr;  // Byte count of the image
         load       <= 1'b1;
      end
      if (rst) begin
         dl_last    <= 1'b0;
         load       <= 1'b0;
         image_size <= '0;
      end
   end

   always_ff @(posedge clk) begin
      byte_valid <= mem_rd & mem_ready;  // Data follows acceptance
      if (mem_rd & mem_ready) begin
         mem_rd   <= 1'b0;
         mem_addr <= mem_addr + 1'b1;
      end
      if (dec_req | fill_req) mem_rd <= 1'b1;
      if (load | rst) begin
         mem_addr   <= '0;
         mem_rd     <= 1'b0;
         byte_valid <= 1'b0;
      end
   end

   assign byte_data = mem_dout;
   assign at_end    = mem_addr >= `UPLOAD_MEM_AW'(image_size);

endmodule

// File: verilog/memory_upload.sv
`include "upload_cfg.svh"

module memory_upload (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      ioctl_download,
   input  logic [15:0]               ioctl_index,
   input  logic [`UPLOAD_RAM_AW-1:0] ioctl_addr,
   input  logic                      reload,
   output logic [`UPLOAD_MEM_AW-1:0] mem_addr,
   output logic                      mem_rd,
   input  logic [7:0]                mem_dout,
   input  logic                      mem_ready,
   output logic [`UPLOAD_RAM_AW-1:0] ram_addr,
   output logic [7:0]                ram_din,
   output logic                      ram_we,
   input  logic                      ram_ready,
   output logic                      busy,
   input  logic [5:0]                slot_idx,
   output msx_pkg::block_t           slot_entry,
   input  logic [3:0]                ref_idx,
   output msx_pkg::lookup_ram_t      ref_entry,
   output msx_pkg::msx_type_t        msx_type,
   output logic [3:0]                expander_en
);
   logic                   load;
   logic                   dec_req;
   logic                   fill_req;
   logic                   byte_valid;
   logic [7:0]             byte_data;
   logic                   at_end;
   logic                   dec_start;
   logic                   rec_valid;
   logic                   rec_ok;
   upload_pkg::record_u    rec;
   logic                   fill_start;
   logic                   fill_done;
   upload_pkg::fill_cmd_t  fill_cmd;
   logic                   store_en;
   upload_pkg::store_cmd_t store_cmd;
   logic                   clear_start;
   logic                   clear_done;

   image_fetch u_fetch (
      .clk, .rst, .ioctl_download, .ioctl_index, .ioctl_addr, .reload, .load,
      .dec_req, .fill_req, .byte_valid, .byte_data, .at_end,
      .mem_addr, .mem_rd, .mem_dout, .mem_ready
   );

   record_decoder u_decoder (
      .clk, .rst, .start(dec_start), .byte_valid, .byte_data,
      .dec_req, .rec_valid, .rec, .rec_ok
   );

   upload_sequencer u_sequencer (
      .clk, .rst, .load, .at_end, .dec_start, .rec_valid, .rec, .rec_ok,
      .fill_start, .fill_cmd, .fill_done, .store_en, .store_cmd,
      .clear_start, .clear_done, .busy, .msx_type, .expander_en
   );

   ram_filler u_filler (
      .clk, .rst, .load, .fill_start, .fill_cmd, .fill_done, .fill_req,
      .byte_valid, .byte_data, .ram_addr, .ram_din, .ram_we, .ram_ready,
      .ref_idx, .ref_entry
   );

   slot_map u_slot_map (
      .clk, .rst, .clear_start, .clear_done, .store_en, .store_cmd,
      .slot_idx, .slot_entry
   );

endmodule

// File: verilog/msx_pkg.sv
`include "upload_cfg.svh"

package msx_pkg;

   typedef enum logic [7:0] {
      MAPPER_UNUSED,
      MAPPER_NONE,
      MAPPER_ASCII8,
      MAPPER_ASCII16,
      MAPPER_KONAMI,
      MAPPER_KONAMI_SCC,
      MAPPER_RAM
   } mapper_t;

   typedef enum logic [7:0] {
      DEVICE_NONE,
      DEVICE_FDC,
      DEVICE_OPL3,
      DEVICE_MFRSD0
   } device_t;

   typedef enum logic [1:0] {MSX1, MSX2, MSX2P, TURBO_R} msx_type_t;

   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;
      logic [1:0] offset_ram;  // 16 KB block inside the region
   } block_t;

   typedef struct packed {
      logic [`UPLOAD_RAM_AW-1:0] addr;
      logic [15:0]               size;   // In 16 KB units
      logic                      ro;
   } lookup_ram_t;

endpackage

// File: verilog/ram_filler.sv
`include "upload_cfg.svh"

module ram_filler (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      load,
   input  logic                      fill_start,
   input  upload_pkg::fill_cmd_t     fill_cmd,
   output logic                      fill_done,
   output logic                      fill_req,
   input  logic                      byte_valid,
   input  logic [7:0]                byte_data,
   output logic [`UPLOAD_RAM_AW-1:0] ram_addr,
   output logic [7:0]                ram_din,
   output logic                      ram_we,
   input  logic                      ram_ready,
   input  logic [3:0]                ref_idx,
   output msx_pkg::lookup_ram_t      ref_entry
);
   typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT, F_WRITE} fstate_t;

   fstate_t                         fstate;
   logic                            copy;
   logic                            we_last;    // Write issued last cycle
   logic [10+`UPLOAD_UNIT_SHIFT:0]  remaining;  // Bytes left in region
   msx_pkg::lookup_ram_t            lookup [`UPLOAD_LOOKUP_ENTRIES];

   assign ram_we = (fstate == F_WRITE) & ram_ready & ~we_last;  // Gap cycle after each write

   always_ff @(posedge clk) begin
      fill_req  <= 1'b0;
      fill_done <= 1'b0;
      we_last   <= ram_we;
      if (ram_we) ram_addr <= ram_addr + 1'b1;
      case (fstate)
         F_IDLE: begin
            if (fill_start) begin
               copy      <= fill_cmd.data_id != upload_pkg::ROM_RAM;
               remaining <= {fill_cmd.size, {`UPLOAD_UNIT_SHIFT{1'b0}}};
               ram_din   <= (fill_cmd.pattern == 2'd2) ? 8'h00 : 8'hFF;
               if (fill_cmd.size == 11'd0) begin
                  fill_done <= 1'b1;
               end else begin
                  lookup[fill_cmd.ref_idx].addr <= ram_addr;
                  lookup[fill_cmd.ref_idx].size <= 16'(fill_cmd.size);
                  lookup[fill_cmd.ref_idx].ro   <= fill_cmd.data_id != upload_pkg::ROM_RAM;
                  fstate <= (fill_cmd.data_id != upload_pkg::ROM_RAM) ? F_REQ : F_WRITE;
               end
            end
         end
         F_REQ: begin
            fill_req <= 1'b1;
            fstate   <= F_WAIT;
         end
         F_WAIT: begin
            if (byte_valid) begin
               ram_din <= byte_data;
               fstate  <= F_WRITE;
            end
         end
         F_WRITE: begin
            if (ram_we) begin
               remaining <= remaining - 1'b1;
               if (remaining == 1) begin
                  fstate    <= F_IDLE;
                  fill_done <= 1'b1;
               end else if (copy) begin
                  fstate <= F_REQ;
               end
            end
         end
         default: ;
      endcase
      if (load) begin
         ram_addr <= '0;
         fstate   <= F_IDLE;
      end
      if (rst) begin
         fstate    <= F_IDLE;
         ram_addr  <= '0;
         we_last   <= 1'b0;
         fill_req  <= 1'b0;
         fill_done <= 1'b0;
         lookup    <= '{default: '0};
      end
   end

   assign ref_entry = lookup[ref_idx];

endmodule

// File: verilog/record_decoder.sv
`include "upload_cfg.svh"

module record_decoder (
   input  logic                clk,
   input  logic                rst,
   input  logic                start,
   input  logic                byte_valid,
   input  logic [7:0]          byte_data,
   output logic                dec_req,
   output logic                rec_valid,
   output upload_pkg::record_u rec,
   output logic                rec_ok
);
   logic       active;
   logic [3:0] count;

   always_ff @(posedge clk) begin
      dec_req   <= 1'b0;
      rec_valid <= 1'b0;
      if (start) begin
         active  <= 1'b1;
         count   <= 4'd0;
         dec_req <= 1'b1;
      end else if (active & byte_valid) begin
         rec   <= {rec[`UPLOAD_RECORD_BYTES*8-9:0], byte_data};  // Shift in, byte 0 ends on top
         count <= count + 1'b1;
         if (count == 4'(`UPLOAD_RECORD_BYTES - 1)) begin
            active    <= 1'b0;
            rec_valid <= 1'b1;
         end else begin
            dec_req <= 1'b1;
         end
      end
      if (rst) begin
         active    <= 1'b0;
         count     <= 4'd0;
         dec_req   <= 1'b0;
         rec_valid <= 1'b0;
      end
   end

   assign rec_ok = rec.slot.sig == `UPLOAD_SIGNATURE;

endmodule

// File: verilog/slot_map.sv
`include "upload_cfg.svh"

module slot_map (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clear_start,
   output logic                   clear_done,
   input  logic                   store_en,
   input  upload_pkg::store_cmd_t store_cmd,
   input  logic [5:0]             slot_idx,
   output msx_pkg::block_t        slot_entry
);
   localparam msx_pkg::block_t BLOCK_CLEAR = '{
      mapper: msx_pkg::MAPPER_UNUSED, device: msx_pkg::DEVICE_NONE,
      ref_ram: 4'd0, offset_ram: 2'd0
   };

   msx_pkg::block_t map [`UPLOAD_SLOT_BLOCKS];
   logic            clearing;
   logic [5:0]      clr_idx;

   // New content of one block for mode field m and param field p
   function automatic msx_pkg::block_t place(input logic [1:0] m, input logic [1:0] p,
                                            input msx_pkg::block_t src,
                                            input upload_pkg::store_cmd_t cmd);
      msx_pkg::block_t e;
      e.mapper     = (m == 2'd3) ? msx_pkg::MAPPER_UNUSED : cmd.mapper;
      e.device     = cmd.device;
      e.ref_ram    = (cmd.data_id == upload_pkg::ROM_NONE) ? 4'd0 : cmd.ref_ram;
      e.offset_ram = p;
      if (m == 2'd1) begin
         e        = src;  // Mirror of another block in the subslot
         e.device = msx_pkg::DEVICE_NONE;
      end
      return e;
   endfunction

   always_ff @(posedge clk) begin
      clear_done <= 1'b0;
      if (clearing) begin
         map[clr_idx] <= BLOCK_CLEAR;
         clr_idx      <= clr_idx + 1'b1;
         if (clr_idx == 6'(`UPLOAD_SLOT_BLOCKS - 1)) begin
            clearing   <= 1'b0;
            clear_done <= 1'b1;
         end
      end else if (store_en) begin
         for (int b = 0; b < 4; b++) begin
            if (store_cmd.mode[2*b +: 2] != 2'd0)
               map[{store_cmd.slot_sub, 2'(b)}] <= place(store_cmd.mode[2*b +: 2],
                  store_cmd.param[2*b +: 2],
                  map[{store_cmd.slot_sub, store_cmd.param[2*b +: 2]}], store_cmd);
         end
      end
      if (clear_start) begin
         clearing <= 1'b1;
         clr_idx  <= 6'd0;
      end
      if (rst) begin
         map        <= '{default: BLOCK_CLEAR};
         clearing   <= 1'b0;
         clr_idx    <= 6'd0;
         clear_done <= 1'b0;
      end
   end

   assign slot_entry = map[slot_idx];

endmodule

// File: verilog/upload_cfg.svh
`ifndef UPLOAD_CFG_SVH
`define UPLOAD_CFG_SVH

`define UPLOAD_RECORD_BYTES    16        // Record header length
`define UPLOAD_UNIT_SHIFT      14        // 16 KB size unit
`define UPLOAD_MEM_AW          28        // External store address width
`define UPLOAD_RAM_AW          27
`define UPLOAD_LOOKUP_ENTRIES  16
`define UPLOAD_SLOT_BLOCKS     64        // 4 slots x 4 subslots x 4 blocks
`define UPLOAD_IMAGE_INDEX     1         // Download index of base image
`define UPLOAD_SIGNATURE       24'h4D5358 // "MSX"

`endif

// File: verilog/upload_pkg.sv
package upload_pkg;

   typedef enum logic [7:0] {
      ROM_NONE,
      ROM_ROM,
      ROM_RAM,
      ROM_FDC
   } data_id_t;

   typedef enum logic [3:0] {
      REC_SLOT_INTERNAL = 4'd0,
      REC_SLOT_A        = 4'd1,
      REC_SLOT_B        = 4'd2,
      REC_SYSTEM        = 4'd3,
      REC_KBD_LAYOUT    = 4'd4
   } rec_kind_t;

   // Byte 0 of the header sits in the top bits
   typedef struct packed {
      logic [23:0]      sig;
      rec_kind_t        kind;
      logic [3:0]       slot_sub;
      data_id_t         data_id;
      logic [15:0]      size;      // 16 KB units
      logic [7:0]       reserved;
      msx_pkg::mapper_t mapper;
      logic [7:0]       mode;      // 2 bits per block
      logic [7:0]       param;
      logic [7:0]       pattern;
      logic [31:0]      padding;
   } slot_view_t;

   typedef struct packed {
      logic [23:0]        sig;
      rec_kind_t          kind;
      logic [3:0]         slot_sub;
      logic [1:0]         spare;
      msx_pkg::msx_type_t msx_type;
      logic [3:0]         expander;
      logic [87:0]        padding;
   } sys_view_t;

   typedef union packed {
      slot_view_t slot;
      sys_view_t  sys;
   } record_u;

   typedef struct packed {
      logic [10:0] size;
      logic [1:0]  pattern;
      data_id_t    data_id;
      logic [3:0]  ref_idx;
   } fill_cmd_t;

   typedef struct packed {
      logic [3:0]       slot_sub;
      msx_pkg::mapper_t mapper;
      msx_pkg::device_t device;
      logic [7:0]       mode;
      logic [7:0]       param;
      logic [3:0]       ref_ram;
      data_id_t         data_id;
   } store_cmd_t;

endpackage

// File: verilog/upload_sequencer.sv
module upload_sequencer (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   load,
   input  logic                   at_end,
   output logic                   dec_start,
   input  logic                   rec_valid,
   input  upload_pkg::record_u    rec,
   input  logic                   rec_ok,
   output logic                   fill_start,
   output upload_pkg::fill_cmd_t  fill_cmd,
   input  logic                   fill_done,
   output logic                   store_en,
   output upload_pkg::store_cmd_t store_cmd,
   output logic                   clear_start,
   input  logic                   clear_done,
   output logic                   busy,
   output msx_pkg::msx_type_t     msx_type,
   output logic [3:0]             expander_en
);
   typedef enum logic [2:0] {ST_IDLE, ST_CLEAR, ST_READ, ST_FILL, ST_STORE} state_t;

   state_t     state;
   logic       reading;   // Header request outstanding
   logic [3:0] ref_ram;

   assign busy = state != ST_IDLE;

   always_ff @(posedge clk) begin
      dec_start   <= 1'b0;
      fill_start  <= 1'b0;
      store_en    <= 1'b0;
      clear_start <= 1'b0;
      case (state)
         ST_CLEAR: if (clear_done) state <= ST_READ;
         ST_READ: begin
            if (!reading) begin
               if (at_end) begin
                  state <= ST_IDLE;
               end else begin
                  dec_start <= 1'b1;
                  reading   <= 1'b1;
               end
            end else if (rec_valid) begin
               reading <= 1'b0;
               if (!rec_ok) begin
                  state <= ST_IDLE;  // Not a record, stop walking
               end else begin
                  case (rec.slot.kind)
                     upload_pkg::REC_SYSTEM: begin
                        msx_type    <= rec.sys.msx_type;
                        expander_en <= rec.sys.expander;
                     end
                     upload_pkg::REC_SLOT_INTERNAL: begin
                        fill_cmd.size       <= rec.slot.size[10:0];
                        fill_cmd.pattern    <= rec.slot.pattern[1:0];
                        fill_cmd.data_id    <= rec.slot.data_id;
                        fill_cmd.ref_idx    <= ref_ram;
                        store_cmd.slot_sub  <= rec.slot.slot_sub;
                        store_cmd.mapper    <= rec.slot.mapper;
                        store_cmd.device    <= (rec.slot.data_id == upload_pkg::ROM_FDC) ?
                                               msx_pkg::DEVICE_FDC : msx_pkg::DEVICE_NONE;
                        store_cmd.mode      <= rec.slot.mode;
                        store_cmd.param     <= rec.slot.param;
                        store_cmd.ref_ram   <= ref_ram;
                        store_cmd.data_id   <= rec.slot.data_id;
                        fill_start          <= 1'b1;
                        state               <= ST_FILL;
                     end
                     default: ;  // Other kinds carry no work here
                  endcase
               end
            end
         end
         ST_FILL: if (fill_done) state <= ST_STORE;
         ST_STORE: begin
            store_en <= 1'b1;
            if (fill_cmd.size != 11'd0) ref_ram <= ref_ram + 1'b1;
            state <= ST_READ;
         end
         default: ;
      endcase
      if (load) begin
         state       <= ST_CLEAR;
         clear_start <= 1'b1;
         reading     <= 1'b0;
         ref_ram     <= 4'd0;
      end
      if (rst) begin
         state       <= ST_IDLE;
         reading     <= 1'b0;
         ref_ram     <= 4'd0;
         dec_start   <= 1'b0;
         fill_start  <= 1'b0;
         store_en    <= 1'b0;
         clear_start <= 1'b0;
         msx_type    <= msx_pkg::MSX1;
         expander_en <= 4'd0;
      end
   end

endmodule
